// ==== design/alu_config.svh ====
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Width of a data word on the operand and result buses.
`define ALU_XLEN 64

// Zero, carry, sign, overflow and illegal.
`define ALU_FLAG_W 5

// Number of execution lanes in the cluster.
`define ALU_LANES 2

// Only this lane is built with a shifter.
`define ALU_SHIFT_LANE 1

`endif

// ==== design/alu_pkg.sv ====
`include "alu_config.svh"

package alu_pkg;

  // Integer operations. Any code above SAR is never issued.
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    CMP = 4'd2, // Subtracts for the flags and writes no result.
    AND = 4'd3,
    OR  = 4'd4,
    XOR = 4'd5,
    SHL = 4'd6,
    SHR = 4'd7,
    SAR = 4'd8
  } alu_op_e;

  // Where an operand comes from at issue.
  typedef enum logic [2:0] {
    SRC_REG     = 3'd0, // Register file value given with the issue.
    SRC_L0_NOW  = 3'd1,
    SRC_L1_NOW  = 3'd2,
    SRC_L0_PREV = 3'd3, // Lane 0 bus as it was one cycle earlier.
    SRC_L1_PREV = 3'd4
  } src_sel_e;

  typedef logic [`ALU_XLEN-1:0] xdata_t;

  // One result bus per lane, lane 0 in the low word.
  typedef xdata_t [`ALU_LANES-1:0] bus_array_t;

  typedef struct packed {
    logic zero;
    logic carry;     // Carry out for add, borrow for sub and cmp.
    logic sign;
    logic overflow;
    logic illegal;   // Operation not supported on this lane.
  } alu_flags_t;

endpackage

// ==== design/lane_if.sv ====
`timescale 1ns/100ps

// Registered issue of one lane, operands already resolved.
interface lane_if;
  import alu_pkg::*;

  logic    valid;
  alu_op_e op;
  logic    is32;  // Operate on the low 32 bits only.
  xdata_t  a;
  xdata_t  b;

  modport src (
    output valid, op, is32, a, b
  );

  modport dst (
    input valid, op, is32, a, b
  );

endinterface

// ==== design/result_if.sv ====
`timescale 1ns/100ps

// Result of one lane before it is committed to its bus.
interface result_if;
  import alu_pkg::*;

  logic       valid;
  logic       wr;     // Low when the result must not reach the bus.
  xdata_t     result;
  alu_flags_t flags;

  modport src (
    output valid, wr, result, flags
  );

  modport dst (
    input valid, wr, result, flags
  );

endinterface

// ==== design/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid,
  input  alu_pkg::alu_op_e     op,
  input  logic                 is32,
  input  alu_pkg::xdata_t      a_reg,
  input  alu_pkg::xdata_t      b_reg,
  input  alu_pkg::src_sel_e    a_src,
  input  alu_pkg::src_sel_e    b_src,
  input  alu_pkg::bus_array_t  bus,
  input  alu_pkg::bus_array_t  bus_prev,
  lane_if.src                  issue
);
  import alu_pkg::*;

  xdata_t a_sel;
  xdata_t b_sel;

  // Picks the register value or one of the four bus taps.
  function automatic xdata_t pick(src_sel_e sel, xdata_t reg_val,
                                  bus_array_t now, bus_array_t prev);
    case (sel)
      SRC_L0_NOW:  pick = now[0];
      SRC_L1_NOW:  pick = now[1];
      SRC_L0_PREV: pick = prev[0];
      SRC_L1_PREV: pick = prev[1];
      default:     pick = reg_val;
    endcase
  endfunction

  assign a_sel = pick(a_src, a_reg, bus, bus_prev);
  assign b_sel = pick(b_src, b_reg, bus, bus_prev);

  always_ff @(posedge clk) begin
    if (rst) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= issue_valid;
    end
  end

  // The payload only moves when something is issued.
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      issue.op   <= op;
      issue.is32 <= is32;
      issue.a    <= a_sel;
      issue.b    <= b_sel;
    end
  end

  a_src_legal: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> (a_src <= SRC_L1_PREV && b_src <= SRC_L1_PREV))
    else $error("operand_forward: undefined source code %0d/%0d", a_src, b_src);

endmodule

// ==== design/alu_shifter.sv ====
`timescale 1ns/100ps

module alu_shifter (
  input  alu_pkg::alu_op_e op,
  input  logic             is32,
  input  alu_pkg::xdata_t  a,
  input  alu_pkg::xdata_t  b,
  output alu_pkg::xdata_t  shifted
);
  import alu_pkg::*;

  logic        [4:0]  cnt32;
  logic        [5:0]  cnt64;
  logic signed [31:0] a32_s;
  logic signed [63:0] a64_s;
  logic        [31:0] lo;

  assign cnt32 = b[4:0];
  assign cnt64 = b[5:0];
  assign a32_s = a[31:0];
  assign a64_s = a;

  always_comb begin
    lo      = '0;
    shifted = '0;
    if (is32) begin
      case (op)
        SHL:     lo = a[31:0] << cnt32;
        SHR:     lo = a[31:0] >> cnt32;
        SAR:     lo = a32_s >>> cnt32; // Fills from bit 31.
        default: lo = '0;
      endcase
      shifted = {32'b0, lo}; // Upper half is zero at 32-bit width.
    end else begin
      case (op)
        SHL:     shifted = a << cnt64;
        SHR:     shifted = a >> cnt64;
        SAR:     shifted = a64_s >>> cnt64;
        default: shifted = '0;
      endcase
    end
  end

endmodule

// ==== design/alu_lane.sv ====
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_lane #(
  parameter bit has_shifter = 1'b0
) (
  input  logic  clk,
  input  logic  rst,
  lane_if.dst   issue,
  result_if.src res
);
  import alu_pkg::*;

  logic               is_sub;
  xdata_t             b_in;
  logic [`ALU_XLEN:0] sum64;
  logic [32:0]        sum32;
  logic               carry_out;
  logic               a_msb;
  logic               b_msb;
  logic               r_msb;
  xdata_t             shifted;
  xdata_t             raw;
  xdata_t             res_w;
  logic               arith;
  logic               wr;
  logic               illegal;

  // Subtraction is a + ~b + 1, so one adder serves add, sub and cmp.
  assign is_sub = issue.op inside {SUB, CMP};
  assign b_in   = is_sub ? ~issue.b : issue.b;
  assign sum64  = {1'b0, issue.a} + {1'b0, b_in} + {{`ALU_XLEN{1'b0}}, is_sub};
  assign sum32  = {1'b0, issue.a[31:0]} + {1'b0, b_in[31:0]} + {32'b0, is_sub};

  assign carry_out = issue.is32 ? sum32[32] : sum64[`ALU_XLEN];
  assign a_msb     = issue.is32 ? issue.a[31] : issue.a[`ALU_XLEN-1];
  assign b_msb     = issue.is32 ? b_in[31] : b_in[`ALU_XLEN-1];

  if (has_shifter) begin : g_shift
    alu_shifter shifter_i (
      .op      (issue.op),
      .is32    (issue.is32),
      .a       (issue.a),
      .b       (issue.b),
      .shifted (shifted)
    );
  end else begin : g_no_shift
    assign shifted = '0; // A shift here returns zero and is flagged illegal.
  end

  always_comb begin
    raw     = sum64[`ALU_XLEN-1:0];
    arith   = 1'b0;
    wr      = 1'b1;
    illegal = 1'b0;
    case (issue.op)
      ADD, SUB: arith = 1'b1;
      CMP: begin
        arith = 1'b1;
        wr    = 1'b0; // Flags only.
      end
      AND:           raw = issue.a & issue.b;
      OR:            raw = issue.a | issue.b;
      XOR:           raw = issue.a ^ issue.b;
      SHL, SHR, SAR: begin
        raw     = shifted;
        illegal = !has_shifter;
      end
      default: begin
        raw     = '0;
        illegal = 1'b1;
      end
    endcase
  end

  assign res_w = issue.is32 ? {32'b0, raw[31:0]} : raw;
  assign r_msb = issue.is32 ? raw[31] : raw[`ALU_XLEN-1];

  assign res.valid  = issue.valid;
  assign res.wr     = wr;
  assign res.result = res_w;

  assign res.flags.zero     = (res_w == '0);
  assign res.flags.carry    = arith && (carry_out ^ is_sub); // Borrow is the inverted carry.
  assign res.flags.sign     = r_msb;
  assign res.flags.overflow = arith && (a_msb == b_msb) && (r_msb != a_msb);
  assign res.flags.illegal  = illegal;

  op_legal: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> issue.op inside {ADD, SUB, CMP, AND, OR, XOR, SHL, SHR, SAR})
    else $error("alu_lane: undefined opcode %0d issued", issue.op);

  operands_known: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> !$isunknown({issue.a, issue.b, issue.is32}))
    else $error("alu_lane: unknown operand bits on a valid issue");

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/100ps
`include "alu_config.svh"

module result_stage (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  except,
  result_if.dst                                 res0,
  result_if.dst                                 res1,
  output alu_pkg::bus_array_t                   bus,
  output alu_pkg::bus_array_t                   bus_prev,
  output alu_pkg::alu_flags_t [`ALU_LANES-1:0]  flags,
  output logic [`ALU_LANES-1:0]                 result_valid
);
  import alu_pkg::*;

  logic       [`ALU_LANES-1:0]                  in_valid;
  logic       [`ALU_LANES-1:0]                  in_wr;
  logic       [`ALU_LANES-1:0]                  take;
  bus_array_t                                   in_result;
  logic       [`ALU_LANES-1:0][`ALU_FLAG_W-1:0] in_flags;
  logic       [`ALU_LANES-1:0][`ALU_FLAG_W-1:0] flag_q;

  assign in_valid  = {res1.valid, res0.valid};
  assign in_wr     = {res1.wr, res0.wr};
  assign in_result = {res1.result, res0.result};
  assign in_flags  = {res1.flags, res0.flags};

  // An exception cancels everything that would commit at this edge.
  assign take = in_valid & {`ALU_LANES{~except}};

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= '0;
      flag_q       <= '0;
      bus          <= '0;
      bus_prev     <= '0;
    end else begin
      result_valid <= take;
      bus_prev     <= bus;
      for (int i = 0; i < `ALU_LANES; i++) begin
        if (take[i]) begin
          flag_q[i] <= in_flags[i];
          if (in_wr[i])
            bus[i] <= in_result[i]; // The bus holds otherwise.
        end
      end
    end
  end

  assign flags = flag_q;

  quiet_after_reset: assert property (@(posedge clk)
    $past(rst) |=> result_valid == '0)
    else $error("result_stage: valid pulse right after reset");

endmodule

// ==== design/alu_cluster_top.sv ====
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_cluster_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  except,
  input  logic [`ALU_LANES-1:0]                 issue_valid,
  input  alu_pkg::alu_op_e [`ALU_LANES-1:0]     op,
  input  logic [`ALU_LANES-1:0]                 is32,
  input  alu_pkg::bus_array_t                   a_reg,
  input  alu_pkg::bus_array_t                   b_reg,
  input  alu_pkg::src_sel_e [`ALU_LANES-1:0]    a_src,
  input  alu_pkg::src_sel_e [`ALU_LANES-1:0]    b_src,
  output alu_pkg::bus_array_t                   result,
  output alu_pkg::alu_flags_t [`ALU_LANES-1:0]  flags,
  output logic [`ALU_LANES-1:0]                 result_valid
);
  import alu_pkg::*;

  bus_array_t bus_prev; // The result outputs double as the current buses.

  lane_if   lane0_if ();
  lane_if   lane1_if ();
  result_if res0_if ();
  result_if res1_if ();

  operand_forward fwd0_i (
    .clk (clk), .rst (rst),
    .issue_valid (issue_valid[0]), .op (op[0]), .is32 (is32[0]),
    .a_reg (a_reg[0]), .b_reg (b_reg[0]), .a_src (a_src[0]), .b_src (b_src[0]),
    .bus (result), .bus_prev (bus_prev),
    .issue (lane0_if.src)
  );

  operand_forward fwd1_i (
    .clk (clk), .rst (rst),
    .issue_valid (issue_valid[1]), .op (op[1]), .is32 (is32[1]),
    .a_reg (a_reg[1]), .b_reg (b_reg[1]), .a_src (a_src[1]), .b_src (b_src[1]),
    .bus (result), .bus_prev (bus_prev),
    .issue (lane1_if.src)
  );

  alu_lane #(.has_shifter (`ALU_SHIFT_LANE == 0)) lane0_i (
    .clk (clk), .rst (rst), .issue (lane0_if.dst), .res (res0_if.src)
  );

  alu_lane #(.has_shifter (`ALU_SHIFT_LANE == 1)) lane1_i (
    .clk (clk), .rst (rst), .issue (lane1_if.dst), .res (res1_if.src)
  );

  result_stage result_i (
    .clk          (clk),
    .rst          (rst),
    .except       (except),
    .res0         (res0_if.dst),
    .res1         (res1_if.dst),
    .bus          (result),
    .bus_prev     (bus_prev),
    .flags        (flags),
    .result_valid (result_valid)
  );

endmodule

// ==== dv/alu_cluster_tb.sv ====
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_cluster_tb;
  import alu_pkg::*;

  localparam int dir_cycles  = 100;
  localparam int rand_cycles = 400;
  localparam int watchdog_ns = (dir_cycles + rand_cycles + 50) * 100;

  typedef struct packed {
    xdata_t     result;
    logic       wr;
    alu_flags_t flags;
  } ref_t;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        except;
  logic [`ALU_LANES-1:0]       issue_valid;
  alu_op_e [`ALU_LANES-1:0]    op;
  logic [`ALU_LANES-1:0]       is32;
  bus_array_t                  a_reg;
  bus_array_t                  b_reg;
  src_sel_e [`ALU_LANES-1:0]   a_src;
  src_sel_e [`ALU_LANES-1:0]   b_src;
  bus_array_t                  result;
  alu_flags_t [`ALU_LANES-1:0] flags;
  logic [`ALU_LANES-1:0]       result_valid;

  integer seed      = 32'h9207;
  int     checks    = 0;
  int     errors    = 0;
  string  test_name = "reset";

  bus_array_t            bus_m;     // Mirror of the result buses.
  bus_array_t            prev_m;
  ref_t                  pend_ref [`ALU_LANES];
  logic [`ALU_LANES-1:0] pend_valid;
  string                 pend_name [`ALU_LANES];
  ref_t                  exp_ref [`ALU_LANES];
  logic [`ALU_LANES-1:0] exp_valid;
  string                 exp_name [`ALU_LANES];

  alu_cluster_top dut_i (
    .clk (clk), .rst (rst), .except (except), .issue_valid (issue_valid),
    .op (op), .is32 (is32), .a_reg (a_reg), .b_reg (b_reg),
    .a_src (a_src), .b_src (b_src),
    .result (result), .flags (flags), .result_valid (result_valid)
  );

  always #50 clk = ~clk;

  // Expected result, write bit and flags of one operation.
  function automatic ref_t alu_ref(alu_op_e op_in, logic w32, xdata_t a, xdata_t b,
                                   bit has_shifter);
    ref_t        r;
    xdata_t      am;
    xdata_t      bm;
    logic [64:0] wide;
    logic [31:0] lo;
    logic [5:0]  cnt;
    logic        sa;
    logic        sb;
    r    = '0;
    r.wr = (op_in != CMP);
    am   = w32 ? {32'b0, a[31:0]} : a;
    bm   = w32 ? {32'b0, b[31:0]} : b;
    cnt  = w32 ? {1'b0, b[4:0]} : b[5:0];
    sa   = w32 ? a[31] : a[63];
    sb   = w32 ? b[31] : b[63];
    case (op_in)
      ADD: begin
        wide          = {1'b0, am} + {1'b0, bm};
        r.result      = wide[63:0];
        r.flags.carry = w32 ? wide[32] : wide[64];
      end
      SUB, CMP: begin
        r.result      = am - bm;
        r.flags.carry = (am < bm); // Unsigned borrow.
      end
      AND: r.result = am & bm;
      OR:  r.result = am | bm;
      XOR: r.result = am ^ bm;
      default: begin
        if (!has_shifter) begin
          r.flags.illegal = 1'b1;
        end else if (w32) begin
          case (op_in)
            SHL:     lo = a[31:0] << cnt;
            SHR:     lo = a[31:0] >> cnt;
            default: lo = (a[31:0] >> cnt) | ({32{a[31]}} & ~(32'hffff_ffff >> cnt));
          endcase
          r.result = {32'b0, lo};
        end else begin
          case (op_in)
            SHL:     r.result = a << cnt;
            SHR:     r.result = a >> cnt;
            default: r.result = (a >> cnt) | ({64{a[63]}} & ~({64{1'b1}} >> cnt));
          endcase
        end
      end
    endcase
    if (w32)
      r.result = {32'b0, r.result[31:0]};
    r.flags.zero = (r.result == '0);
    r.flags.sign = w32 ? r.result[31] : r.result[63];
    if (op_in == ADD)
      r.flags.overflow = (sa == sb) && (r.flags.sign != sa);
    else if (op_in == SUB || op_in == CMP)
      r.flags.overflow = (sa != sb) && (r.flags.sign != sa);
    return r;
  endfunction

  function automatic xdata_t forward(src_sel_e sel, xdata_t reg_val);
    case (sel)
      SRC_L0_NOW:  return bus_m[0];
      SRC_L1_NOW:  return bus_m[1];
      SRC_L0_PREV: return prev_m[0];
      SRC_L1_PREV: return prev_m[1];
      default:     return reg_val;
    endcase
  endfunction

  function automatic xdata_t rand_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r % 8)
      0:       return '0;
      1:       return '1;
      2:       return 64'h8000_0000_0000_0000;
      3:       return 64'h0000_0000_7fff_ffff;
      4:       return {$random(seed), 32'hffff_ffff};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  task automatic drive(int lane, alu_op_e o, logic w32, xdata_t a, xdata_t b,
                       src_sel_e sa = SRC_REG, src_sel_e sb = SRC_REG);
    issue_valid[lane] = 1'b1;
    op[lane]          = o;
    is32[lane]        = w32;
    a_reg[lane]       = a;
    b_reg[lane]       = b;
    a_src[lane]       = sa;
    b_src[lane]       = sb;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    issue_valid = '0;
    except      = 1'b0;
  endtask

  // Lane 1 gets the operands swapped.
  task automatic both_lanes(alu_op_e o, logic w32, xdata_t a, xdata_t b);
    drive(0, o, w32, a, b);
    drive(1, o, w32, b, a);
    next_cycle();
  endtask

  task automatic shifts(logic w32, xdata_t a, xdata_t b);
    drive(0, SHR, w32, a, b); // Lane 0 has no shifter.
    drive(1, SHL, w32, a, b);
    next_cycle();
    drive(1, SHR, w32, a, b);
    next_cycle();
    drive(1, SAR, w32, a, b);
    next_cycle();
  endtask

  // The model resolves new issues against the old buses, then commits the previous ones.
  always @(posedge clk) begin
    ref_t                  nxt_ref [`ALU_LANES];
    string                 nxt_name [`ALU_LANES];
    logic [`ALU_LANES-1:0] nxt_valid;
    if (rst) begin
      bus_m      = '0;
      prev_m     = '0;
      pend_valid = '0;
      exp_valid  = '0;
      for (int i = 0; i < `ALU_LANES; i++)
        exp_name[i] = "reset";
    end else begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        nxt_ref[i]   = alu_ref(op[i], is32[i], forward(a_src[i], a_reg[i]),
                               forward(b_src[i], b_reg[i]), i == `ALU_SHIFT_LANE);
        nxt_valid[i] = issue_valid[i];
        nxt_name[i]  = test_name;
      end
      prev_m = bus_m;
      for (int i = 0; i < `ALU_LANES; i++) begin
        exp_valid[i] = pend_valid[i] && !except;
        if (exp_valid[i]) begin
          exp_ref[i]  = pend_ref[i];
          exp_name[i] = pend_name[i];
          if (pend_ref[i].wr)
            bus_m[i] = pend_ref[i].result;
        end
      end
      pend_valid = nxt_valid;
      pend_ref   = nxt_ref;
      pend_name  = nxt_name;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        checks++;
        assert (result_valid[i] === exp_valid[i]) else begin
          errors++;
          if (exp_valid[i])
            $display("Lane %0d: no valid pulse for a %s operation", i, exp_name[i]);
          else
            $display("Lane %0d: valid pulse with no operation due", i);
        end
        assert (result[i] === bus_m[i]) else begin
          errors++;
          $display("[FAIL] %s lane %0d result: expected %h, actual %h",
                   exp_name[i], i, bus_m[i], result[i]);
        end
        if (exp_valid[i]) begin
          assert (flags[i] === exp_ref[i].flags) else begin
            errors++;
            $display("[FAIL] %s lane %0d flags: expected %b, actual %b",
                     exp_name[i], i, exp_ref[i].flags, flags[i]);
          end
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    except      = 1'b0;
    issue_valid = '0;
    is32        = '0;
    a_reg       = '0;
    b_reg       = '0;
    for (int i = 0; i < `ALU_LANES; i++) begin
      op[i]    = ADD;
      a_src[i] = SRC_REG;
      b_src[i] = SRC_REG;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (result_valid == '0 && result == '0) else begin
      errors++;
      $display("Outputs were not cleared by reset");
    end

    test_name = "add";
    both_lanes(ADD, 1'b0, '1, 64'd1);
    both_lanes(ADD, 1'b0, 64'h7fff_ffff_ffff_ffff, 64'd1);
    both_lanes(ADD, 1'b1, 64'h1234_5678_ffff_ffff, 64'hdead_0000_0000_0001);
    both_lanes(ADD, 1'b1, 64'h7fff_ffff, 64'd1);
    test_name = "sub";
    both_lanes(SUB, 1'b0, 64'd0, 64'd1);
    both_lanes(SUB, 1'b0, 64'h8000_0000_0000_0000, 64'd1);
    both_lanes(SUB, 1'b1, 64'hffff_0000_0000_0005, 64'd5);
    both_lanes(SUB, 1'b1, 64'h8000_0000, 64'd1);
    test_name = "cmp";
    both_lanes(CMP, 1'b0, 64'd3, 64'd5);
    both_lanes(CMP, 1'b1, 64'h1_0000_0007, 64'd7);
    both_lanes(CMP, 1'b0, 64'h8000_0000_0000_0000, 64'd1);

    test_name = "logic";
    for (int k = 0; k < 2; k++) begin
      both_lanes(AND, k[0], rand_operand(), rand_operand());
      both_lanes(OR, k[0], rand_operand(), rand_operand());
      both_lanes(XOR, k[0], rand_operand(), rand_operand());
    end

    test_name = "shift";
    shifts(1'b0, 64'h8000_0000_0000_0001, 64'd0);
    shifts(1'b0, 64'h8000_0000_0000_0001, 64'd1);
    shifts(1'b0, 64'hf000_0000_0000_000f, 64'd63);
    shifts(1'b0, 64'h8765_4321_0fed_cba9, 64'h47); // Only the low 6 bits count.
    shifts(1'b1, 64'hffff_ffff_8000_0001, 64'd31);
    shifts(1'b1, 64'h0000_0000_8000_00f0, 64'd36);
    shifts(1'b1, 64'h1234_5678_4000_0000, 64'd0);

    test_name = "forward";
    drive(0, ADD, 1'b0, 64'd10, 64'd20);
    drive(1, SUB, 1'b0, 64'd100, 64'd1);
    next_cycle();
    drive(0, ADD, 1'b0, 64'd0, 64'd1, SRC_L1_NOW, SRC_REG);
    drive(1, XOR, 1'b0, 64'd0, 64'd0, SRC_L0_NOW, SRC_L1_NOW);
    next_cycle();
    drive(0, ADD, 1'b0, 64'd0, 64'd0, SRC_L1_NOW, SRC_L1_PREV);
    drive(1, SUB, 1'b1, 64'd0, 64'd0, SRC_L0_PREV, SRC_L0_NOW);
    next_cycle();
    drive(0, OR, 1'b0, 64'd0, 64'd0, SRC_L0_PREV, SRC_L1_PREV);
    drive(1, SHL, 1'b0, 64'd0, 64'd3, SRC_L1_NOW, SRC_REG);
    next_cycle();
    drive(0, CMP, 1'b0, 64'd0, 64'd0, SRC_L0_NOW, SRC_L1_NOW);
    drive(1, ADD, 1'b0, 64'd0, 64'd0, SRC_L1_PREV, SRC_L0_NOW);
    next_cycle();

    test_name = "except";
    drive(0, ADD, 1'b0, 64'd1, 64'd2);
    drive(1, SUB, 1'b0, 64'd9, 64'd4);
    next_cycle();
    except = 1'b1; // Cancels the pair issued one cycle earlier.
    drive(0, XOR, 1'b0, 64'hff, 64'h0f);
    drive(1, AND, 1'b1, 64'hffff, 64'hf0f0);
    next_cycle();
    next_cycle();

    test_name = "random";
    repeat (rand_cycles) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        if (rand_word() % 8 != 0)
          drive(i, alu_op_e'(4'(rand_word() % 9)), rand_word() % 2 == 1,
                rand_operand(), rand_operand(),
                src_sel_e'(3'(rand_word() % 5)), src_sel_e'(3'(rand_word() % 5)));
      end
      except = (rand_word() % 32 == 0);
      @(posedge clk);
      #1;
      issue_valid = '0;
      except      = 1'b0;
    end

    repeat (3) next_cycle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+design
design/alu_pkg.sv
design/lane_if.sv
design/result_if.sv
design/operand_forward.sv
design/alu_shifter.sv
design/alu_lane.sv
design/result_stage.sv
design/alu_cluster_top.sv
dv/alu_cluster_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := alu_cluster_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF 'All tests passed!' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
